//--- hw/bootLdrPkg.sv
// Flash boot loader package
// Widths, SPI flash command codes, wait times and ROM geometry,
// plus the structs shared between the loader blocks

package bootLdrPkg;

  typedef logic [7:0]  byteT;
  typedef logic [31:0] flashAddrT;
  typedef logic [28:0] romAddrT;
  typedef logic [63:0] romWordT;
  typedef logic [7:0]  delayT;

  // One ROM write, 94 bits
  typedef struct packed {
    logic    en;
    romAddrT addr;
    romWordT data;
  } romWrT;

  // Flash pins driven by the loader
  typedef struct packed {
    logic sck;
    logic mosi;
    logic csN;
  } spiPinsT;

  // ROM geometry
  localparam romAddrT romBase  = 29'h0;
  localparam romAddrT romWords = 29'd16;

  // SCK half period in clkH cycles
  localparam logic [3:0] spiHalfPeriod = 4'd2;

  // Flash commands
  localparam byteT cmdResetEnable = 8'h66;
  localparam byteT cmdReset       = 8'h99;
  localparam byteT cmdWake        = 8'hAB;
  localparam byteT cmdReadId      = 8'h9F;
  localparam byteT cmdRead3       = 8'h03;
  localparam byteT cmdRead4       = 8'h13;
  localparam byteT dummyByte      = 8'hFF;

  // Size codes above this need 4 address bytes
  localparam byteT addr4bLimit = 8'h18;

  // Waits after the wake and ID frames
  localparam delayT waitShort = 8'd63;
  localparam delayT waitLong  = 8'd255;

endpackage

//--- hw/spiByteEngine.sv
// SPI byte engine
// Mode-0 master, one byte out and one byte in per send request.
// MOSI moves on falling SCK, MISO is sampled on rising SCK, MSB first

`timescale 1ns/1ps

module spiByteEngine (
  input  logic             clkH,
  input  logic             rstN,
  input  logic             send,
  input  bootLdrPkg::byteT txByte,
  output logic             busy,
  output logic             recv,
  output bootLdrPkg::byteT rxByte,
  output logic             spiSck,
  output logic             spiMosi,
  input  logic             spiMiso
);

  logic [3:0]       halfCnt;
  logic [3:0]       phase;
  logic             halfEnd;
  logic             riseNow;
  bootLdrPkg::byteT shiftReg;

  assign halfEnd = busy && (halfCnt == bootLdrPkg::spiHalfPeriod - 4'd1);

  // Even phases end with SCK going high
  assign riseNow = halfEnd && !phase[0];

  // Received bits collect in the shift register
  assign rxByte = shiftReg;

  always_ff @(posedge clkH) begin
    if (!rstN) begin
      busy    <= 1'b0;
      recv    <= 1'b0;
      spiSck  <= 1'b0;
      spiMosi <= 1'b0;
      halfCnt <= '0;
      phase   <= '0;
    end else begin
      recv <= 1'b0;
      if (send) begin
        busy    <= 1'b1;
        halfCnt <= '0;
        phase   <= '0;
        spiMosi <= txByte[7];
      end else if (halfEnd) begin
        halfCnt <= '0;
        phase   <= phase + 4'd1;
        spiSck  <= ~spiSck;
        if (phase == 4'd15) begin
          // Last falling edge
          busy    <= 1'b0;
          recv    <= 1'b1;
          spiMosi <= 1'b0;
        end else if (phase[0]) begin
          spiMosi <= shiftReg[7];
        end
      end else if (busy) begin
        halfCnt <= halfCnt + 4'd1;
      end
    end
  end

  // Shift out on load, sample in at each rising edge
  always_ff @(posedge clkH) begin
    if (send) begin
      shiftReg <= txByte;
    end else if (riseNow) begin
      shiftReg <= {shiftReg[6:0], spiMiso};
    end
  end

  // Sequencer must wait for the previous byte
  sendWhileBusy: assert property (@(posedge clkH) disable iff (!rstN) send |-> !busy)
    else $error("send while SPI engine busy");

endmodule

//--- hw/flashBootSeq.sv
// Flash boot sequencer
// Wakes and resets the flash, reads the JEDEC ID, issues the read
// command and keeps reading until the ROM image is complete

`timescale 1ns/1ps

module flashBootSeq (
  input  logic                  clkH,
  input  logic                  rstN,
  input  logic                  startReq,
  output logic                  startAck,
  input  bootLdrPkg::flashAddrT loadAddr,
  output logic                  send,
  output bootLdrPkg::byteT      txByte,
  input  logic                  busy,
  input  logic                  recv,
  input  bootLdrPkg::byteT      rxByte,
  output logic                  csN,
  output logic                  dataByte,
  output bootLdrPkg::byteT      dataByteValue,
  output logic                  loadStart,
  input  logic                  loadDone,
  output logic                  active
);

  typedef enum logic [3:0] {
    stIdle,
    stWakeSend,
    stWakeXfer,
    stWakeWait,
    stIdSend,
    stIdXfer,
    stIdWait,
    stCmdSend,
    stCmdXfer,
    stDataSend,
    stDataXfer,
    stDataGap,
    stAck
  } seqStateT;

  seqStateT          state;
  logic [1:0]        wakeIdx;
  logic [2:0]        byteCnt;
  bootLdrPkg::delayT delay;
  bootLdrPkg::byteT  sizeCode;
  logic              addr4b;
  logic [2:0]        lastCmdByte;
  logic [2:0]        addrShift;
  logic              sendState;

  assign addr4b      = sizeCode > bootLdrPkg::addr4bLimit;
  assign lastCmdByte = addr4b ? 3'd4 : 3'd3;
  // Address bytes left after this one
  assign addrShift   = lastCmdByte - byteCnt;

  assign sendState = (state == stWakeSend) || (state == stIdSend) ||
                     (state == stCmdSend) || (state == stDataSend && !loadDone);
  assign send      = sendState && !busy;

  assign loadStart     = (state == stIdle) && startReq;
  assign dataByte      = (state == stDataXfer) && recv;
  assign dataByteValue = rxByte;
  assign startAck      = (state == stAck);
  assign active        = (state != stIdle);

  always_comb begin
    txByte = bootLdrPkg::dummyByte;
    case (state)
      stWakeSend: begin
        case (wakeIdx)
          2'd0:    txByte = bootLdrPkg::cmdResetEnable;
          2'd1:    txByte = bootLdrPkg::cmdReset;
          default: txByte = bootLdrPkg::cmdWake;
        endcase
      end
      stIdSend: begin
        if (byteCnt == 3'd0) begin
          txByte = bootLdrPkg::cmdReadId;
        end
      end
      stCmdSend: begin
        if (byteCnt == 3'd0) begin
          txByte = addr4b ? bootLdrPkg::cmdRead4 : bootLdrPkg::cmdRead3;
        end else begin
          txByte = bootLdrPkg::byteT'(loadAddr >> {addrShift, 3'b000});
        end
      end
      default: txByte = bootLdrPkg::dummyByte;
    endcase
  end

  always_ff @(posedge clkH) begin
    if (!rstN) begin
      state   <= stIdle;
      csN     <= 1'b1;
      wakeIdx <= '0;
      byteCnt <= '0;
      delay   <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (startReq) begin
            csN     <= 1'b0;
            wakeIdx <= '0;
            state   <= stWakeSend;
          end
        end
        stWakeSend: if (!busy) state <= stWakeXfer;
        stWakeXfer: begin
          if (recv) begin
            csN   <= 1'b1;
            delay <= (wakeIdx == 2'd0) ? bootLdrPkg::waitShort : bootLdrPkg::waitLong;
            state <= stWakeWait;
          end
        end
        stWakeWait: begin
          if (delay != '0) begin
            delay <= delay - 8'd1;
          end else begin
            csN     <= 1'b0;
            byteCnt <= '0;
            if (wakeIdx == 2'd2) begin
              state <= stIdSend;
            end else begin
              wakeIdx <= wakeIdx + 2'd1;
              state   <= stWakeSend;
            end
          end
        end
        stIdSend: if (!busy) state <= stIdXfer;
        stIdXfer: begin
          if (recv) begin
            if (byteCnt == 3'd3) begin
              // Third ID byte holds the size code
              sizeCode <= rxByte;
              csN      <= 1'b1;
              delay    <= bootLdrPkg::waitLong;
              state    <= stIdWait;
            end else begin
              byteCnt <= byteCnt + 3'd1;
              state   <= stIdSend;
            end
          end
        end
        stIdWait: begin
          if (delay != '0) begin
            delay <= delay - 8'd1;
          end else begin
            csN     <= 1'b0;
            byteCnt <= '0;
            state   <= stCmdSend;
          end
        end
        stCmdSend: if (!busy) state <= stCmdXfer;
        stCmdXfer: begin
          if (recv) begin
            if (byteCnt == lastCmdByte) begin
              state <= stDataSend;
            end else begin
              byteCnt <= byteCnt + 3'd1;
              state   <= stCmdSend;
            end
          end
        end
        stDataSend: begin
          if (loadDone) begin
            csN   <= 1'b1;
            state <= stAck;
          end else if (!busy) begin
            state <= stDataXfer;
          end
        end
        stDataXfer: if (recv) state <= stDataGap;
        // Lets loadDone settle after a word write
        stDataGap: state <= stDataSend;
        stAck: if (!startReq) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  idleCsHigh: assert property (@(posedge clkH) disable iff (!rstN) (state == stIdle) |-> csN)
    else $error("flash selected while loader idle");

endmodule

//--- hw/romWordPacker.sv
// ROM word packer
// Collects eight flash bytes per 64-bit word, first byte in the low bits,
// and writes the words to ascending ROM addresses

`timescale 1ns/1ps

module romWordPacker (
  input  logic              clkH,
  input  logic              rstN,
  input  logic              loadStart,
  input  logic              dataByte,
  input  bootLdrPkg::byteT  dataByteValue,
  output bootLdrPkg::romWrT romWr,
  output logic              loadDone
);

  bootLdrPkg::romWordT shiftWord;
  bootLdrPkg::romAddrT wordCnt;
  logic [2:0]          byteCnt;
  logic                wrEn;

  // New bytes enter at the top
  always_ff @(posedge clkH) begin
    if (dataByte) begin
      shiftWord <= {dataByteValue, shiftWord[63:8]};
    end
  end

  always_ff @(posedge clkH) begin
    if (!rstN) begin
      byteCnt  <= '0;
      wordCnt  <= '0;
      wrEn     <= 1'b0;
      loadDone <= 1'b0;
    end else begin
      wrEn <= dataByte && (byteCnt == 3'd7);
      if (loadStart) begin
        byteCnt  <= '0;
        wordCnt  <= '0;
        loadDone <= 1'b0;
      end else begin
        if (dataByte) begin
          byteCnt <= byteCnt + 3'd1;
        end
        if (wrEn) begin
          wordCnt <= wordCnt + bootLdrPkg::romAddrT'(1);
          if (wordCnt == bootLdrPkg::romWords - bootLdrPkg::romAddrT'(1)) begin
            loadDone <= 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    romWr.en   = wrEn;
    romWr.addr = bootLdrPkg::romBase + wordCnt;
    romWr.data = shiftWord;
  end

  // Image is complete once loadDone rises
  noWriteAfterDone: assert property (@(posedge clkH) disable iff (!rstN) wrEn |-> !loadDone)
    else $error("ROM write after load done");

endmodule

//--- hw/flashBootLdr.sv
// Flash boot loader top
// Copies a program image from SPI flash into the on-chip ROM
// on each start request, with a four-phase req/ack handshake

`timescale 1ns/1ps

module flashBootLdr (
  input  logic                  clkH,
  input  logic                  rstN,
  input  logic                  startReq,
  output logic                  startAck,
  input  bootLdrPkg::flashAddrT loadAddr,
  output bootLdrPkg::spiPinsT   spiPins,
  input  logic                  spiMiso,
  output bootLdrPkg::romWrT     romWr,
  output logic                  active
);

  logic             send;
  logic             busy;
  logic             recv;
  bootLdrPkg::byteT txByte;
  bootLdrPkg::byteT rxByte;
  logic             csN;
  logic             spiSck;
  logic             spiMosi;
  logic             dataByte;
  bootLdrPkg::byteT dataByteValue;
  logic             loadStart;
  logic             loadDone;

  flashBootSeq seq (
    .clkH(clkH),
    .rstN(rstN),
    .startReq(startReq),
    .startAck(startAck),
    .loadAddr(loadAddr),
    .send(send),
    .txByte(txByte),
    .busy(busy),
    .recv(recv),
    .rxByte(rxByte),
    .csN(csN),
    .dataByte(dataByte),
    .dataByteValue(dataByteValue),
    .loadStart(loadStart),
    .loadDone(loadDone),
    .active(active)
  );

  spiByteEngine engine (
    .clkH(clkH),
    .rstN(rstN),
    .send(send),
    .txByte(txByte),
    .busy(busy),
    .recv(recv),
    .rxByte(rxByte),
    .spiSck(spiSck),
    .spiMosi(spiMosi),
    .spiMiso(spiMiso)
  );

  romWordPacker packer (
    .clkH(clkH),
    .rstN(rstN),
    .loadStart(loadStart),
    .dataByte(dataByte),
    .dataByteValue(dataByteValue),
    .romWr(romWr),
    .loadDone(loadDone)
  );

  // Chip select comes from the sequencer, clock and data from the engine
  assign spiPins = '{sck: spiSck, mosi: spiMosi, csN: csN};

endmodule

//--- bench/tbClock.sv
// Testbench clock
// Free-running clock with a 20 ns period

`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  initial clk = 1'b0;

  always #10 clk = ~clk;

endmodule

//--- bench/spiFlashModel.sv
// Behavioral SPI flash
// Mode-0 slave that keeps the first bytes of each frame and answers
// the JEDEC ID and read commands

`timescale 1ns/1ps

module spiFlashModel (
  input  logic             sck,
  input  logic             mosi,
  input  logic             csN,
  output logic             miso,
  input  bootLdrPkg::byteT sizeCode,
  output logic [39:0]      frameHead,
  output int               frameLen
);

  bootLdrPkg::byteT      inSr;
  bootLdrPkg::byteT      outSr = 8'hFF;
  bootLdrPkg::byteT      nextOut;
  bootLdrPkg::byteT      cmd;
  bootLdrPkg::flashAddrT addr;
  logic [2:0]            bitCnt;
  int                    addrBytes;

  assign miso = outSr[7];

  // Image content as a function of the byte address
  function automatic bootLdrPkg::byteT memByte(input bootLdrPkg::flashAddrT a);
    bootLdrPkg::flashAddrT mix;
    mix = a ^ (a >> 8) ^ 32'h0000_005A;
    return mix[7:0];
  endfunction

  // SCK is low whenever csN falls, so a low SCK here means frame start
  always @(negedge csN or posedge sck) begin
    if (!sck) begin
      bitCnt    = 3'd0;
      frameLen  = 0;
      frameHead = '0;
      addr      = '0;
      nextOut   = 8'hFF;
    end else begin
      inSr   = {inSr[6:0], mosi};
      bitCnt = bitCnt + 3'd1;
      if (bitCnt == 3'd0) begin
        if (frameLen == 0) begin
          cmd = inSr;
        end
        if (frameLen < 5) begin
          frameHead[39 - 8 * frameLen -: 8] = inSr;
        end
        frameLen  = frameLen + 1;
        nextOut   = 8'hFF;
        addrBytes = (cmd == 8'h13) ? 4 : 3;
        if (cmd == 8'h9F) begin
          case (frameLen)
            1:       nextOut = 8'hEF;
            2:       nextOut = 8'h40;
            3:       nextOut = sizeCode;
            default: nextOut = 8'hFF;
          endcase
        end else if (cmd == 8'h03 || cmd == 8'h13) begin
          if (frameLen > 1 && frameLen <= addrBytes + 1) begin
            addr = {addr[23:0], inSr};
          end
          if (frameLen > addrBytes) begin
            nextOut = memByte(addr);
            addr    = addr + 1;
          end
        end
      end
    end
  end

  // Next bit goes out on the falling edge
  always @(negedge sck) begin
    if (!csN) begin
      outSr <= (bitCnt == 3'd0) ? nextOut : {outSr[6:0], 1'b1};
    end
  end

endmodule

//--- bench/tbFlashBootLdr.sv
// Flash boot loader testbench
// Six random loads through the req/ack handshake, checked against
// a flash image model and a log of ROM writes

`timescale 1ns/1ps

module tbFlashBootLdr;

  localparam int runs          = 6;
  localparam int runCycles     = 6000;
  localparam int timeoutCycles = runs * runCycles + 4000;

  logic                  clk;
  logic                  rstN;
  logic                  startReq;
  logic                  startAck;
  bootLdrPkg::flashAddrT loadAddr;
  bootLdrPkg::spiPinsT   spiPins;
  logic                  spiMiso;
  bootLdrPkg::romWrT     romWr;
  logic                  active;
  bootLdrPkg::byteT      flashSize;
  logic [39:0]           frameHead;
  int                    frameLen;

  logic [31:0]         lfsr = 32'hbf55_be39;
  int                  errorCount = 0;
  int                  cycleCount = 0;
  logic                prevCs = 1'b1;
  logic [39:0]         frameHeads[$];
  int                  frameLens[$];
  bootLdrPkg::romAddrT romAddrs[$];
  bootLdrPkg::romWordT romData[$];

  tbClock clockGen (.clk(clk));

  flashBootLdr flashBootLdr_inst (
    .clkH(clk),
    .rstN(rstN),
    .startReq(startReq),
    .startAck(startAck),
    .loadAddr(loadAddr),
    .spiPins(spiPins),
    .spiMiso(spiMiso),
    .romWr(romWr),
    .active(active)
  );

  spiFlashModel flash (
    .sck(spiPins.sck),
    .mosi(spiPins.mosi),
    .csN(spiPins.csN),
    .miso(spiMiso),
    .sizeCode(flashSize),
    .frameHead(frameHead),
    .frameLen(frameLen)
  );

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  function automatic bootLdrPkg::byteT flashByte(input logic [31:0] a);
    logic [31:0] mix;
    mix = a ^ (a >> 8) ^ 32'h0000_005A;
    return mix[7:0];
  endfunction

  task automatic reportError(input string msg);
    errorCount++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic checkIdle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (spiPins.csN && !spiPins.sck && !romWr.en && !startAck && !active)
        else reportError("loader not idle between runs");
    end
  endtask

  task automatic doRun(input int idx);
    logic [31:0]         r;
    logic [31:0]         base;
    logic                headOk;
    int                  addrBytes;
    bootLdrPkg::romWordT word;

    drawBits(32, base);
    drawBits(5, r);
    frameHeads.delete();
    frameLens.delete();
    romAddrs.delete();
    romData.delete();
    stepCycle();
    loadAddr  = base;
    flashSize = (idx % 2 == 0) ? bootLdrPkg::byteT'(r % 32'd25) : bootLdrPkg::byteT'(r + 32'd25);
    startReq  = 1'b1;
    @(negedge clk);
    while (!startAck) begin
      @(negedge clk);
    end
    assert (romAddrs.size() == 16)
      else reportError($sformatf("startAck after %0d ROM writes", romAddrs.size()));
    drawBits(3, r);
    repeat (r[2:0]) begin
      @(negedge clk);
      assert (startAck) else reportError("startAck dropped while startReq high");
    end
    stepCycle();
    startReq = 1'b0;
    // Ack holds until the next edge sees the request low
    @(negedge clk);
    @(negedge clk);
    assert (!startAck && !active) else reportError("startAck still high after startReq fell");

    assert (frameHeads.size() == 5)
      else reportError($sformatf("%0d flash frames, expected 5", frameHeads.size()));
    if (frameHeads.size() == 5) begin
      for (int f = 0; f < 3; f++) begin
        assert (frameLens[f] == 1 && frameHeads[f][39:32] == 8'(24'h6699AB >> (16 - 8 * f)))
          else reportError($sformatf("wake frame %0d is %h", f, frameHeads[f]));
      end
      assert (frameLens[3] == 4 && frameHeads[3][39:8] == 32'h9FFF_FFFF)
        else reportError($sformatf("ID frame %h, length %0d", frameHeads[3], frameLens[3]));
      addrBytes = (flashSize > 8'h18) ? 4 : 3;
      headOk    = (addrBytes == 4) ? (frameHeads[4] == {8'h13, base}) :
                                     (frameHeads[4][39:8] == {8'h03, base[23:0]});
      assert (headOk && frameLens[4] == 129 + addrBytes)
        else reportError($sformatf("read frame %h, length %0d, size code %h", frameHeads[4],
                                   frameLens[4], flashSize));
      if (addrBytes == 3) begin
        base = {8'h00, base[23:0]};
      end
    end
    for (int i = 0; i < romAddrs.size() && i < 16; i++) begin
      for (int j = 0; j < 8; j++) begin
        word[8 * j +: 8] = flashByte(base + 32'(8 * i + j));
      end
      assert (romAddrs[i] == bootLdrPkg::romBase + 29'(i) && romData[i] == word)
        else reportError($sformatf("write %0d at %h is %h, expected %h", i, romAddrs[i],
                                   romData[i], word));
    end
  endtask

  // Frame and ROM write log, sampled away from the clock edge
  always @(negedge clk) begin
    if (rstN) begin
      if (spiPins.csN && !prevCs) begin
        frameHeads.push_back(frameHead);
        frameLens.push_back(frameLen);
      end
      if (romWr.en) begin
        assert (active && !startAck) else reportError("ROM write outside a load");
        romAddrs.push_back(romWr.addr);
        romData.push_back(romWr.data);
      end
    end
    prevCs = spiPins.csN;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount == timeoutCycles) begin
      $display("Timeout: loads not finished after %0d cycles", cycleCount);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] gap;

    rstN      = 1'b0;
    startReq  = 1'b0;
    loadAddr  = '0;
    flashSize = 8'h18;
    repeat (16) stepCycle();
    rstN = 1'b1;
    checkIdle(4);
    for (int i = 0; i < runs; i++) begin
      doRun(i);
      drawBits(3, gap);
      checkIdle(2 + int'(gap));
    end
    $display("Done: %0d runs, %0d errors", runs, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- flashBootLdr.f
hw/bootLdrPkg.sv
hw/spiByteEngine.sv
hw/flashBootSeq.sv
hw/romWordPacker.sv
hw/flashBootLdr.sv
bench/tbClock.sv
bench/spiFlashModel.sv
bench/tbFlashBootLdr.sv

//--- Makefile
# Verilator build and run of the flash boot loader testbench

SRCS := $(shell cat flashBootLdr.f)

obj_dir/VtbFlashBootLdr: flashBootLdr.f $(SRCS)
	verilator --binary --timing --assert --top-module tbFlashBootLdr -f flashBootLdr.f

run: obj_dir/VtbFlashBootLdr
	./obj_dir/VtbFlashBootLdr | awk '{ print } /^All checks passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean
